/* hw/bus_pkg.sv */
package bus_pkg;

    //////////////////////////////////////////////////
    // Plain widths
    //////////////////////////////////////////////////

    typedef logic [15:0] addr_t;
    typedef logic [7:0]  data_t;

    // External bank address and bank register contents
    typedef logic [4:0]  bank_t;

    // One hand controller, active low buttons
    typedef logic [7:0]  pad_t;

    typedef logic [1:0]  region_t;

    typedef enum logic {
        SPACE_MEM = 1'b0,
        SPACE_IO  = 1'b1
    } access_space_e;

    //////////////////////////////////////////////////
    // Grouped signals
    //////////////////////////////////////////////////

    // Z80 strobes, all active low
    typedef struct packed {
        logic rd_n;
        logic wr_n;
        logic mreq_n;
        logic iorq_n;
    } bus_ctrl_t;

    // One captured bus write
    typedef struct packed {
        addr_t         addr;
        data_t         data;
        access_space_e space;
    } bus_write_t;

    // Register state seen by the bus decoder
    typedef struct packed {
        bank_t   bank0;
        bank_t   bank1;
        bank_t   bank2;
        logic    startup;
        region_t region;
    } sys_state_t;

endpackage

/* hw/port_map_pkg.sv */
package port_map_pkg;

    //////////////////////////////////////////////////
    // Memory mapped system registers
    //////////////////////////////////////////////////

    localparam logic [15:0] ADDR_RAMCTRL = 16'hFFFC;
    localparam logic [15:0] ADDR_BANK0   = 16'hFFFD;
    localparam logic [15:0] ADDR_BANK1   = 16'hFFFE;
    localparam logic [15:0] ADDR_BANK2   = 16'hFFFF;

    // Below this address bank 0 is not applied
    localparam logic [15:0] BANK0_LOW_LIMIT = 16'h0400;

    //////////////////////////////////////////////////
    // IO ports, code is {a[7], a[6], a[0]}
    //////////////////////////////////////////////////

    localparam logic [2:0] IO_CODE_REGION  = 3'b001;
    localparam logic [2:0] IO_CODE_PORT_DC = 3'b110;
    localparam logic [2:0] IO_CODE_PORT_DD = 3'b111;

    // Values after reset
    localparam logic [4:0] BANK0_RESET  = 5'd0;
    localparam logic [4:0] BANK1_RESET  = 5'd1;
    localparam logic [4:0] BANK2_RESET  = 5'd2;
    localparam logic [1:0] REGION_RESET = 2'b11;

    // Bit positions within a hand controller input
    localparam int PAD_DOWN  = 0;
    localparam int PAD_RIGHT = 1;
    localparam int PAD_UP    = 2;
    localparam int PAD_LEFT  = 3;
    localparam int PAD_TL    = 5;
    localparam int PAD_TR    = 6;

    localparam logic [7:0] IDLE_READ_DATA = 8'hFF;

endpackage

/* hw/bus_write_capture.sv */
`timescale 1ns/1ps

module bus_write_capture
    import bus_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    // Live Z80 bus
    input  addr_t      bus_a,
    input  data_t      bus_d_in,
    input  bus_ctrl_t  bus_ctrl,

    // Towards the write FIFO
    input  logic       full,
    output logic       push,
    output bus_write_t push_rec,

    output logic       write_lost
);

    // wr_n history, bit 0 is the newest sample
    logic [2:0] wr_n_sync;
    logic       write_edge;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_n_sync <= 3'b111;
        end else begin
            wr_n_sync <= {wr_n_sync[1:0], bus_ctrl.wr_n};
        end
    end

    // Falling edge seen between stages two and three
    assign write_edge = wr_n_sync[2] & ~wr_n_sync[1];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            push       <= 1'b0;
            write_lost <= 1'b0;
        end else begin
            push <= write_edge & ~full;
            // Sticky until the next reset
            if (write_edge && full) begin
                write_lost <= 1'b1;
            end
        end
    end

    // Address and data are stable by now, so sample them live
    always_ff @(posedge clk) begin
        if (write_edge) begin
            push_rec.addr  <= bus_a;
            push_rec.data  <= bus_d_in;
            push_rec.space <= bus_ctrl.iorq_n ? SPACE_MEM : SPACE_IO;
        end
    end

endmodule

/* hw/write_fifo.sv */
`timescale 1ns/1ps

module write_fifo
    import bus_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic          clk,
    input  logic          reset,

    // Write side
    input  logic          push,
    input  bus_write_t    push_rec,
    output logic          full,

    // Wishbone classic master
    output logic          wb_cyc,
    output logic          wb_stb,
    output logic          wb_we,
    output addr_t         wb_adr,
    output data_t         wb_dat,
    output access_space_e wb_io,
    input  logic          wb_ack
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] count_t;

    bus_write_t mem [FIFO_DEPTH];
    ptr_t       wr_ptr;
    ptr_t       rd_ptr;
    count_t     count;
    logic       wr_en;
    logic       rd_en;
    bus_write_t head;

    assign full  = (count == count_t'(FIFO_DEPTH));
    assign wr_en = push & ~full;
    assign rd_en = wb_cyc & wb_ack;

    // Storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_rec;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == ptr_t'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == ptr_t'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Head record on the bus
    //////////////////////////////////////////////////

    assign head   = mem[rd_ptr];
    assign wb_cyc = (count != '0);
    assign wb_stb = wb_cyc;
    assign wb_we  = 1'b1;
    assign wb_adr = head.addr;
    assign wb_dat = head.data;
    assign wb_io  = head.space;

endmodule

/* hw/system_regs.sv */
`timescale 1ns/1ps

module system_regs
    import bus_pkg::*;
    import port_map_pkg::*;
(
    input  logic          clk,
    input  logic          reset,

    // Wishbone classic slave
    input  logic          wb_cyc,
    input  logic          wb_stb,
    input  logic          wb_we,
    input  addr_t         wb_adr,
    input  data_t         wb_dat,
    input  access_space_e wb_io,
    output logic          wb_ack,

    output sys_state_t    sys_state
);

    logic       wr_req;
    logic       mem_wr;
    logic       io_wr;
    logic [2:0] io_code;

    // New request only when no ack is outstanding
    assign wr_req  = wb_cyc & wb_stb & ~wb_ack;
    assign mem_wr  = wr_req & wb_we & (wb_io == SPACE_MEM);
    assign io_wr   = wr_req & wb_we & (wb_io == SPACE_IO);

    // Partial IO decode as on the console
    assign io_code = {wb_adr[7], wb_adr[6], wb_adr[0]};

    //////////////////////////////////////////////////
    // Ack and register updates
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_ack            <= 1'b0;
            sys_state.bank0   <= BANK0_RESET;
            sys_state.bank1   <= BANK1_RESET;
            sys_state.bank2   <= BANK2_RESET;
            sys_state.startup <= 1'b1;
            sys_state.region  <= REGION_RESET;
        end else begin
            // Single cycle ack, write applied on the same edge
            wb_ack <= wr_req;

            if (mem_wr) begin
                case (wb_adr)
                    ADDR_RAMCTRL: sys_state.startup <= 1'b0;
                    ADDR_BANK0:   sys_state.bank0   <= wb_dat[4:0];
                    ADDR_BANK1:   sys_state.bank1   <= wb_dat[4:0];
                    ADDR_BANK2:   sys_state.bank2   <= wb_dat[4:0];
                    default: ;
                endcase
            end

            // Region bits sit in data bits 7 and 5
            if (io_wr && io_code == IO_CODE_REGION) begin
                sys_state.region <= {wb_dat[7], wb_dat[5]};
            end
        end
    end

endmodule

/* hw/bus_decode.sv */
`timescale 1ns/1ps

module bus_decode
    import bus_pkg::*;
    import port_map_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    input  addr_t      bus_a,
    input  bus_ctrl_t  bus_ctrl,

    // Hand controllers, asynchronous
    input  pad_t       hc1,
    input  pad_t       hc2,

    input  sys_state_t sys_state,

    output bank_t      bus_ba,
    output logic       ram_ce_n,
    output logic       ram_we_n,
    output data_t      rd_data,
    output logic       rd_data_en
);

    pad_t       hc1_meta;
    pad_t       hc1_sync;
    pad_t       hc2_meta;
    pad_t       hc2_sync;
    logic       ram_sel;
    logic [2:0] io_code;
    data_t      port_dc;
    data_t      port_dd;

    //////////////////////////////////////////////////
    // Bank address
    //////////////////////////////////////////////////

    always_comb begin
        bus_ba = '0;
        if (bus_a >= BANK0_LOW_LIMIT) begin
            case (bus_a[15:14])
                2'b00:   bus_ba = sys_state.bank0;
                2'b01:   bus_ba = sys_state.bank1;
                2'b10:   bus_ba = sys_state.bank2;
                default: bus_ba = '0;
            endcase
        end
    end

    // External RAM is only writable during startup
    assign ram_sel  = ~bus_ctrl.mreq_n & bus_ctrl.iorq_n
                    & (bus_ctrl.wr_n | sys_state.startup);
    assign ram_ce_n = ~ram_sel;
    assign ram_we_n = ~(ram_sel & ~bus_ctrl.wr_n & sys_state.startup);

    //////////////////////////////////////////////////
    // Hand controller sync
    //////////////////////////////////////////////////

    // Idle buttons read as ones
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hc1_meta <= '1;
            hc1_sync <= '1;
            hc2_meta <= '1;
            hc2_sync <= '1;
        end else begin
            hc1_meta <= hc1;
            hc1_sync <= hc1_meta;
            hc2_meta <= hc2;
            hc2_sync <= hc2_meta;
        end
    end

    //////////////////////////////////////////////////
    // Read data
    //////////////////////////////////////////////////

    assign port_dc = {hc2_sync[PAD_DOWN], hc2_sync[PAD_UP],
                      hc1_sync[PAD_TR], hc1_sync[PAD_TL],
                      hc1_sync[PAD_RIGHT], hc1_sync[PAD_LEFT],
                      hc1_sync[PAD_DOWN], hc1_sync[PAD_UP]};

    assign port_dd = {sys_state.region, 2'b11,
                      hc2_sync[PAD_TR], hc2_sync[PAD_TL],
                      hc2_sync[PAD_RIGHT], hc2_sync[PAD_LEFT]};

    assign io_code = {bus_a[7], bus_a[6], bus_a[0]};

    always_comb begin
        case (io_code)
            IO_CODE_PORT_DC: rd_data = port_dc;
            IO_CODE_PORT_DD: rd_data = port_dd;
            default:         rd_data = IDLE_READ_DATA;
        endcase
    end

    assign rd_data_en = ~bus_ctrl.rd_n & ~bus_ctrl.iorq_n;

endmodule

/* hw/sms_bus_top.sv */
`timescale 1ns/1ps

module sms_bus_top
    import bus_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic      clk,
    input  logic      reset,

    // Z80 bus
    input  addr_t     bus_a,
    input  data_t     bus_d_in,
    input  bus_ctrl_t bus_ctrl,

    // Hand controllers
    input  pad_t      hc1,
    input  pad_t      hc2,

    output bank_t     bus_ba,
    output logic      ram_ce_n,
    output logic      ram_we_n,
    output data_t     rd_data,
    output logic      rd_data_en,
    output logic      write_lost
);

    // Capture to FIFO
    logic          push;
    bus_write_t    push_rec;
    logic          full;

    // FIFO to register block
    logic          wb_cyc;
    logic          wb_stb;
    logic          wb_we;
    addr_t         wb_adr;
    data_t         wb_dat;
    access_space_e wb_io;
    logic          wb_ack;

    sys_state_t    sys_state;

    //////////////////////////////////////////////////
    // Write path
    //////////////////////////////////////////////////

    bus_write_capture u_capture (
        .clk        (clk),
        .reset      (reset),
        .bus_a      (bus_a),
        .bus_d_in   (bus_d_in),
        .bus_ctrl   (bus_ctrl),
        .full       (full),
        .push       (push),
        .push_rec   (push_rec),
        .write_lost (write_lost)
    );

    write_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk      (clk),
        .reset    (reset),
        .push     (push),
        .push_rec (push_rec),
        .full     (full),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat   (wb_dat),
        .wb_io    (wb_io),
        .wb_ack   (wb_ack)
    );

    system_regs u_regs (
        .clk       (clk),
        .reset     (reset),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat    (wb_dat),
        .wb_io     (wb_io),
        .wb_ack    (wb_ack),
        .sys_state (sys_state)
    );

    // Banking, RAM enables and readback
    bus_decode u_decode (
        .clk        (clk),
        .reset      (reset),
        .bus_a      (bus_a),
        .bus_ctrl   (bus_ctrl),
        .hc1        (hc1),
        .hc2        (hc2),
        .sys_state  (sys_state),
        .bus_ba     (bus_ba),
        .ram_ce_n   (ram_ce_n),
        .ram_we_n   (ram_we_n),
        .rd_data    (rd_data),
        .rd_data_en (rd_data_en)
    );

endmodule

/* tb/sms_bus_assertions.sv */
`timescale 1ns/1ps

module sms_bus_assertions
    import bus_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input bus_ctrl_t bus_ctrl,
    input logic      rd_data_en,
    input logic      ram_ce_n,
    input logic      ram_we_n,
    input logic      wb_stb,
    input logic      wb_ack
);

    // Read by the testbench at the end of the run
    int failures = 0;

    // Read data is only offered during a read strobe
    rd_en_needs_rd: assert property (
        @(posedge clk) disable iff (reset)
        rd_data_en |-> !bus_ctrl.rd_n
    ) else begin
        failures++;
        $error("rd_data_en high while rd_n is high");
    end

    // RAM write enable never without chip enable
    we_needs_ce: assert property (
        @(posedge clk) disable iff (reset)
        !ram_we_n |-> !ram_ce_n
    ) else begin
        failures++;
        $error("ram_we_n low while ram_ce_n is high");
    end

    //////////////////////////////////////////////////
    // Wishbone ack
    //////////////////////////////////////////////////

    ack_with_stb: assert property (
        @(posedge clk) disable iff (reset)
        wb_ack |-> wb_stb
    ) else begin
        failures++;
        $error("wb_ack without wb_stb");
    end

    ack_single_cycle: assert property (
        @(posedge clk) disable iff (reset)
        wb_ack |=> !wb_ack
    ) else begin
        failures++;
        $error("wb_ack high in two consecutive cycles");
    end

endmodule

bind sms_bus_top sms_bus_assertions u_assertions (
    .clk        (clk),
    .reset      (reset),
    .bus_ctrl   (bus_ctrl),
    .rd_data_en (rd_data_en),
    .ram_ce_n   (ram_ce_n),
    .ram_we_n   (ram_we_n),
    .wb_stb     (wb_stb),
    .wb_ack     (wb_ack)
);

/* tb/sms_bus_tb.sv */
`timescale 1ns/1ps

module sms_bus_tb
    import bus_pkg::*;
    import port_map_pkg::*;
();

    // Limit well above the length of all tests
    localparam int MAX_CYCLES = 5000;

    logic      clk;
    logic      reset;
    addr_t     bus_a;
    data_t     bus_d_in;
    bus_ctrl_t bus_ctrl;
    pad_t      hc1;
    pad_t      hc2;
    bank_t     bus_ba;
    logic      ram_ce_n;
    logic      ram_we_n;
    data_t     rd_data;
    logic      rd_data_en;
    logic      write_lost;

    integer    seed;
    int        error_count = 0;
    int        check_count = 0;
    int        test_start_errors;
    int        assert_failures;
    // RAM enables seen in the middle of the last write strobe
    logic      wr_ce_n;
    logic      wr_we_n;
    region_t   exp_region;

    sms_bus_top #(
        .FIFO_DEPTH (4)
    ) dut (
        .clk        (clk),
        .reset      (reset),
        .bus_a      (bus_a),
        .bus_d_in   (bus_d_in),
        .bus_ctrl   (bus_ctrl),
        .hc1        (hc1),
        .hc2        (hc2),
        .bus_ba     (bus_ba),
        .ram_ce_n   (ram_ce_n),
        .ram_we_n   (ram_we_n),
        .rd_data    (rd_data),
        .rd_data_en (rd_data_en),
        .write_lost (write_lost)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic check_data(input string what, input data_t got, input data_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bank(input string what, input bank_t got, input bank_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    //////////////////////////////////////////////////
    // Bus tasks
    //////////////////////////////////////////////////

    // Strobe held 8 cycles, then 8 idle cycles
    task automatic bus_write(input access_space_e space, input addr_t addr, input data_t data);
        @(negedge clk);
        bus_a           = addr;
        bus_d_in        = data;
        bus_ctrl        = '1;
        bus_ctrl.wr_n   = 1'b0;
        bus_ctrl.mreq_n = (space == SPACE_IO);
        bus_ctrl.iorq_n = (space == SPACE_MEM);
        repeat (4) @(posedge clk);
        wr_ce_n = ram_ce_n;
        wr_we_n = ram_we_n;
        repeat (5) @(negedge clk);
        bus_ctrl = '1;
        repeat (8) @(negedge clk);
    endtask

    task automatic bus_mem_write(input addr_t addr, input data_t data);
        bus_write(SPACE_MEM, addr, data);
    endtask

    task automatic bus_io_write(input addr_t addr, input data_t data);
        bus_write(SPACE_IO, addr, data);
    endtask

    task automatic bus_io_read(input addr_t addr, output data_t data);
        @(negedge clk);
        bus_a           = addr;
        bus_ctrl        = '1;
        bus_ctrl.rd_n   = 1'b0;
        bus_ctrl.iorq_n = 1'b0;
        @(posedge clk);
        data = rd_data;
        check_bit("rd_data_en", rd_data_en, 1'b1);
        @(negedge clk);
        bus_ctrl = '1;
    endtask

    task automatic mem_read_ce(input addr_t addr, output logic ce_n);
        @(negedge clk);
        bus_a           = addr;
        bus_ctrl        = '1;
        bus_ctrl.rd_n   = 1'b0;
        bus_ctrl.mreq_n = 1'b0;
        @(posedge clk);
        ce_n = ram_ce_n;
        @(negedge clk);
        bus_ctrl = '1;
    endtask

    task automatic probe_bank(input addr_t addr, input bank_t exp);
        @(negedge clk);
        bus_a = addr;
        @(posedge clk);
        check_bank($sformatf("bus_ba at %h", addr), bus_ba, exp);
    endtask

    task automatic end_test(input string name);
        if (error_count == test_start_errors) begin
            $display("Test %s: passed", name);
        end else begin
            $display("Test %s: %0d errors", name, error_count - test_start_errors);
        end
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic test_reset_state();
        data_t rd;
        test_start_errors = error_count;
        probe_bank(16'h0100, 5'd0);
        probe_bank(16'h0400, 5'd0);
        probe_bank(16'h4000, 5'd1);
        probe_bank(16'h8000, 5'd2);
        probe_bank(16'hC000, 5'd0);
        bus_io_read(16'h00DD, rd);
        check_bit("port DD bit 7", rd[7], 1'b1);
        check_bit("port DD bit 6", rd[6], 1'b1);
        check_bit("write_lost", write_lost, 1'b0);
        end_test("reset_state");
    endtask

    task automatic test_banking();
        test_start_errors = error_count;
        bus_mem_write(ADDR_BANK2, 8'h33);
        bus_mem_write(ADDR_BANK1, 8'h0A);
        bus_mem_write(ADDR_BANK0, 8'h1F);
        // Low 5 bits of each data byte
        probe_bank(16'h8000, 5'h13);
        probe_bank(16'h4000, 5'h0A);
        probe_bank(16'h0400, 5'h1F);
        probe_bank(16'h03FF, 5'h00);
        end_test("banking");
    endtask

    task automatic test_startup();
        logic ce_n;
        test_start_errors = error_count;
        bus_mem_write(16'h2000, 8'h5A);
        check_bit("ram_ce_n on write in startup", wr_ce_n, 1'b0);
        check_bit("ram_we_n on write in startup", wr_we_n, 1'b0);
        bus_mem_write(ADDR_RAMCTRL, 8'h00);
        bus_mem_write(16'h2000, 8'h5A);
        check_bit("ram_ce_n on write after startup", wr_ce_n, 1'b1);
        check_bit("ram_we_n on write after startup", wr_we_n, 1'b1);
        mem_read_ce(16'h2000, ce_n);
        check_bit("ram_ce_n on read after startup", ce_n, 1'b0);
        end_test("startup");
    endtask

    task automatic test_region();
        data_t   values[3]      = '{8'hA0, 8'h20, 8'h00};
        region_t exp_regions[3] = '{2'b11, 2'b01, 2'b00};
        data_t   rd;
        test_start_errors = error_count;
        foreach (values[i]) begin
            bus_io_write(16'h003F, values[i]);
            exp_region = exp_regions[i];
            bus_io_read(16'h00DD, rd);
            check_data("port DD region bits", rd & 8'hC0, {exp_region, 6'b0});
        end
        end_test("region");
    endtask

    task automatic test_joypad();
        data_t rd;
        data_t exp_dc;
        data_t exp_dd;
        test_start_errors = error_count;
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            hc1 = pad_t'($random(seed));
            hc2 = pad_t'($random(seed));
            repeat (4) @(negedge clk);
            exp_dc = {hc2[PAD_DOWN], hc2[PAD_UP], hc1[PAD_TR], hc1[PAD_TL],
                      hc1[PAD_RIGHT], hc1[PAD_LEFT], hc1[PAD_DOWN], hc1[PAD_UP]};
            exp_dd = {exp_region, 2'b11, hc2[PAD_TR], hc2[PAD_TL],
                      hc2[PAD_RIGHT], hc2[PAD_LEFT]};
            bus_io_read(16'h00DC, rd);
            check_data("port DC", rd, exp_dc);
            bus_io_read(16'h00DD, rd);
            check_data("port DD", rd, exp_dd);
        end
        bus_io_read(16'h0040, rd);
        check_data("port 40", rd, 8'hFF);
        end_test("joypad");
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        reset      = 1'b1;
        bus_a      = '0;
        bus_d_in   = '0;
        bus_ctrl   = '1;
        hc1        = '1;
        hc2        = '1;
        seed       = 32'h59bc0aee;
        exp_region = 2'b11;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_reset_state();
        test_banking();
        test_startup();
        test_region();
        test_joypad();

        assert_failures = dut.u_assertions.failures;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, assert_failures);
        if (error_count == 0 && assert_failures == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* sms_bus_top.f */
hw/bus_pkg.sv
hw/port_map_pkg.sv
hw/bus_write_capture.sv
hw/write_fifo.sv
hw/system_regs.sv
hw/bus_decode.sv
hw/sms_bus_top.sv
tb/sms_bus_assertions.sv
tb/sms_bus_tb.sv

/* Bender.yml */
package:
  name: sms_bus

sources:
  - hw/bus_pkg.sv
  - hw/port_map_pkg.sv
  - hw/bus_write_capture.sv
  - hw/write_fifo.sv
  - hw/system_regs.sv
  - hw/bus_decode.sv
  - hw/sms_bus_top.sv
  - target: test
    files:
      - tb/sms_bus_assertions.sv
      - tb/sms_bus_tb.sv
